// ==== verilog/ex_consts.svh ====
// execute stage constants for widths, ALU and branch flag positions and opcodes
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define XLEN  64
`define ALU_W 12
`define BJ_W  8

// positions inside alu_op_t, where add is the most significant field
`define ALU_ADD  11
`define ALU_SUB  10
`define ALU_SLT  9
`define ALU_SLTU 8
`define ALU_XOR  7
`define ALU_OR   6
`define ALU_AND  5
`define ALU_SLL  4
`define ALU_SRL  3
`define ALU_SRA  2
`define ALU_ANDN 1
`define ALU_WRI  0

`define BJ_BEQ  0
`define BJ_BNE  1
`define BJ_BLT  2
`define BJ_BGE  3
`define BJ_BLTU 4
`define BJ_BGEU 5
`define BJ_JALR 6
`define BJ_JAL  7

`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011

`endif

// ==== verilog/ex_pkg.sv ====
// execute stage types for the command, the result, the ALU operation and the instruction word
`include "ex_consts.svh"

package ex_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_instr_i_t;

  // the same word seen as register form or immediate form
  typedef union packed {
    rv_instr_r_t r;
    rv_instr_i_t i;
  } rv_instr_u;

  typedef struct packed {
    logic add;
    logic sub;
    logic slt;
    logic sltu;
    logic xor_;
    logic or_;
    logic and_;
    logic sll;
    logic srl;
    logic sra;
    logic andn;
    logic wri;
  } alu_op_t;

  typedef struct packed {
    rv_instr_u        instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
  } ex_cmd_t;

  typedef struct packed {
    logic [`XLEN-1:0] rd_val;
    logic [`XLEN-1:0] next_pc;
    logic [4:0]       rd_addr;
    logic             wr_en;
    logic             redirect;
  } ex_res_t;

endpackage

// ==== verilog/ex_decoder.sv ====
// execute decoder that builds the ALU operation, operands, immediate and branch selection
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_decoder import ex_pkg::*; (
  input  rv_instr_u        instr,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_val,
  input  logic [`XLEN-1:0] rs2_val,
  output alu_op_t          alu_op,
  output logic [`XLEN-1:0] op1,
  output logic [`XLEN-1:0] op2,
  output logic [`XLEN-1:0] imm,
  output logic             is_word_opt,
  output logic             is_jalr,
  output logic             legal,
  output logic [`BJ_W-1:0] bj_sel
);

  logic [31:0]       word;
  logic [`XLEN-1:0]  imm_i;
  logic [`XLEN-1:0]  imm_u;
  logic [`XLEN-1:0]  imm_b;
  logic [`XLEN-1:0]  imm_j;
  logic [`ALU_W-1:0] op_vec;
  logic              is_imm;
  logic              is_word;
  logic              alt;

  assign word  = instr;
  assign imm_i = {{52{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_u = {{32{word[31]}}, word[31:12], 12'b0};
  assign imm_b = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
  assign imm_j = {{43{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

  assign is_imm  = (instr.r.opcode == `OPC_OP_IMM) || (instr.r.opcode == `OPC_OP_IMM_32);
  assign is_word = (instr.r.opcode == `OPC_OP_32) || (instr.r.opcode == `OPC_OP_IMM_32);
  // funct7 bit 5 selects sub, sra and andn, and it is imm12 bit 10 in the I view
  assign alt     = instr.r.funct7[5];

  // legal marks a recognised instruction that writes rd, so branches leave it low
  always_comb begin
    op_vec      = '0;
    op1         = rs1_val;
    op2         = is_imm ? imm_i : rs2_val;
    imm         = imm_i;
    is_word_opt = 1'b0;
    is_jalr     = 1'b0;
    legal       = 1'b0;
    bj_sel      = '0;
    case (instr.r.opcode)
      `OPC_OP, `OPC_OP_32, `OPC_OP_IMM, `OPC_OP_IMM_32: begin
        legal       = 1'b1;
        is_word_opt = is_word;
        case (instr.r.funct3)
          3'b000: op_vec[(alt && !is_imm) ? `ALU_SUB : `ALU_ADD] = 1'b1;
          3'b001: op_vec[`ALU_SLL] = 1'b1;
          3'b010: op_vec[`ALU_SLT] = 1'b1;
          3'b011: op_vec[`ALU_SLTU] = 1'b1;
          3'b100: op_vec[`ALU_XOR] = 1'b1;
          3'b101: begin
            op_vec[alt ? `ALU_SRA : `ALU_SRL] = 1'b1;
            // word right shifts must not pull in the upper half of rs1
            if (is_word) begin
              op1 = {32'b0, rs1_val[31:0]};
            end
          end
          3'b110: op_vec[`ALU_OR] = 1'b1;
          default: begin
            if (alt && !is_imm) begin
              // the ALU computes ~op1 & op2, andn wants rs1 & ~rs2
              op_vec[`ALU_ANDN] = 1'b1;
              op1               = rs2_val;
              op2               = rs1_val;
            end else begin
              op_vec[`ALU_AND] = 1'b1;
            end
          end
        endcase
      end
      `OPC_LUI: begin
        legal            = 1'b1;
        op_vec[`ALU_WRI] = 1'b1;
        op2              = imm_u;
        imm              = imm_u;
      end
      `OPC_AUIPC: begin
        legal            = 1'b1;
        op_vec[`ALU_ADD] = 1'b1;
        op1              = pc;
        op2              = imm_u;
        imm              = imm_u;
      end
      `OPC_JAL, `OPC_JALR: begin
        legal            = 1'b1;
        op_vec[`ALU_ADD] = 1'b1;
        op1              = pc;
        op2              = `XLEN'(4);
        is_jalr          = (instr.r.opcode == `OPC_JALR);
        imm              = is_jalr ? imm_i : imm_j;
        bj_sel[is_jalr ? `BJ_JALR : `BJ_JAL] = 1'b1;
      end
      `OPC_BRANCH: begin
        imm = imm_b;
        case (instr.r.funct3)
          3'b000: bj_sel[`BJ_BEQ] = 1'b1;
          3'b001: bj_sel[`BJ_BNE] = 1'b1;
          3'b100: bj_sel[`BJ_BLT] = 1'b1;
          3'b101: bj_sel[`BJ_BGE] = 1'b1;
          3'b110: bj_sel[`BJ_BLTU] = 1'b1;
          3'b111: bj_sel[`BJ_BGEU] = 1'b1;
          default: bj_sel = '0;
        endcase
        // signed and unsigned compares need the matching adder extension
        op_vec[`ALU_SUB]  = (instr.r.funct3[2:1] == 2'b00);
        op_vec[`ALU_SLT]  = (instr.r.funct3[2:1] == 2'b10);
        op_vec[`ALU_SLTU] = (instr.r.funct3[2:1] == 2'b11);
      end
      default: legal = 1'b0;
    endcase
  end

  assign alu_op = alu_op_t'(op_vec);

endmodule

// ==== verilog/ex_stage_alu.sv ====
// 64-bit integer ALU with one shared left shifter, one adder and the branch compare flags
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_stage_alu import ex_pkg::*; (
  input  logic [`XLEN-1:0] op1,
  input  logic [`XLEN-1:0] op2,
  input  alu_op_t          alu_info,
  input  logic             is_word_opt,
  output logic [`XLEN-1:0] alu_output,
  output logic [`BJ_W-1:0] bj_data
);

  function automatic logic [`XLEN-1:0] bit_rev(input logic [`XLEN-1:0] v);
    logic [`XLEN-1:0] r;
    for (int i = 0; i < `XLEN; i++) begin
      r[i] = v[`XLEN-1-i];
    end
    return r;
  endfunction

  logic             op_right;
  logic             op_shift;
  logic [5:0]       shamt;
  logic [`XLEN-1:0] shift_in;
  logic [`XLEN-1:0] shift_res;
  logic [`XLEN-1:0] srl_res;
  logic [`XLEN-1:0] eff_mask;
  logic [`XLEN-1:0] sign_fill;
  logic [`XLEN-1:0] sra_res;
  logic             op_sub_like;
  logic             op_addsub;
  logic [`XLEN:0]   adder_a;
  logic [`XLEN:0]   adder_b;
  logic [`XLEN:0]   add_res;
  logic             less;
  logic [`XLEN-1:0] xor_res;
  logic [`XLEN-1:0] temp_output;
  logic             eq_res;

  // right shifts run through the left shifter on the bit-reversed operand
  assign op_right  = alu_info.srl | alu_info.sra;
  assign op_shift  = alu_info.sll | op_right;
  assign shamt     = {6{op_shift}} & (is_word_opt ? {1'b0, op2[4:0]} : op2[5:0]);
  assign shift_in  = {`XLEN{op_shift}} & (op_right ? bit_rev(op1) : op1);
  assign shift_res = shift_in << shamt;
  assign srl_res   = bit_rev(shift_res);

  // bits outside the mask are the ones an arithmetic shift fills with the sign
  assign eff_mask  = (is_word_opt ? {32'b0, {32{1'b1}}} : {`XLEN{1'b1}}) >> shamt;
  assign sign_fill = is_word_opt ? {32'b0, {32{op1[31]}}} : {`XLEN{op1[63]}};
  assign sra_res   = (srl_res & eff_mask) | (sign_fill & ~eff_mask);

  // 65-bit adder, sign extended except for sltu so bit 64 gives the compare
  assign op_sub_like = alu_info.sub | alu_info.slt | alu_info.sltu;
  assign op_addsub   = alu_info.add | op_sub_like;
  assign adder_a     = {(`XLEN+1){op_addsub}} & {~alu_info.sltu & op1[63], op1};
  assign adder_b     = {(`XLEN+1){op_addsub}} &
                       (op_sub_like ? ~{~alu_info.sltu & op2[63], op2}
                                    : {~alu_info.sltu & op2[63], op2});
  assign add_res     = adder_a + adder_b + {{`XLEN{1'b0}}, op_sub_like};
  assign less        = (alu_info.slt | alu_info.sltu) & add_res[`XLEN];

  assign xor_res = op1 ^ op2;

  assign temp_output = ({`XLEN{alu_info.sll}} & shift_res)
                     | ({`XLEN{alu_info.srl}} & srl_res)
                     | ({`XLEN{alu_info.sra}} & sra_res)
                     | ({`XLEN{alu_info.slt | alu_info.sltu}} & {{(`XLEN-1){1'b0}}, less})
                     | ({`XLEN{alu_info.add | alu_info.sub}} & add_res[`XLEN-1:0])
                     | ({`XLEN{alu_info.xor_}} & xor_res)
                     | ({`XLEN{alu_info.or_}} & (op1 | op2))
                     | ({`XLEN{alu_info.and_}} & (op1 & op2))
                     | ({`XLEN{alu_info.andn}} & (~op1 & op2))
                     | ({`XLEN{alu_info.wri}} & op2);

  assign alu_output = {is_word_opt ? {32{temp_output[31]}} : temp_output[63:32],
                       temp_output[31:0]};

  // lt and ltu are only meaningful when the decoder picked the matching compare
  assign eq_res            = ~(|xor_res);
  assign bj_data[`BJ_BEQ]  = eq_res;
  assign bj_data[`BJ_BNE]  = ~eq_res;
  assign bj_data[`BJ_BLT]  = less;
  assign bj_data[`BJ_BGE]  = ~less;
  assign bj_data[`BJ_BLTU] = less;
  assign bj_data[`BJ_BGEU] = ~less;
  assign bj_data[`BJ_JALR] = 1'b1;
  assign bj_data[`BJ_JAL]  = 1'b1;

endmodule

// ==== verilog/ex_branch_resolve.sv ====
// branch resolver that turns compare flags and the branch selection into redirect and next pc
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_branch_resolve (
  input  logic [`BJ_W-1:0] bj_data,
  input  logic [`BJ_W-1:0] bj_sel,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_val,
  input  logic [`XLEN-1:0] imm,
  input  logic             is_jalr,
  output logic             redirect,
  output logic [`XLEN-1:0] next_pc
);

  logic [`XLEN-1:0] base;
  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] target;

  // bj_sel is one-hot or zero, so no selection means fall through
  assign redirect = |(bj_data & bj_sel);

  assign base   = is_jalr ? rs1_val : pc;
  assign sum    = base + imm;
  // jalr drops bit 0 of the computed address
  assign target = is_jalr ? {sum[`XLEN-1:1], 1'b0} : sum;

  assign next_pc = redirect ? target : pc + `XLEN'(4);

endmodule

// ==== verilog/ex_stage.sv ====
// integer execute stage top with a four-phase req/ack controller around decoder, ALU and branch unit
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_stage import ex_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    req,
  input  ex_cmd_t cmd,
  output logic    ack,
  output ex_res_t res
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_DONE
  } state_t;

  state_t           state;
  ex_cmd_t          cmd_q;
  ex_res_t          res_d;
  alu_op_t          alu_op;
  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] alu_output;
  logic [`XLEN-1:0] next_pc;
  logic [`BJ_W-1:0] bj_sel;
  logic [`BJ_W-1:0] bj_data;
  logic             is_word_opt;
  logic             is_jalr;
  logic             legal;
  logic             redirect;

  // idle accepts, busy registers the result, done waits for req to drop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
      ack   <= 1'b0;
      res   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            state <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          res   <= res_d;
          ack   <= 1'b1;
          state <= ST_DONE;
        end
        ST_DONE: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      cmd_q <= cmd;
    end
  end

  ex_decoder i_ex_decoder (
    .instr       (cmd_q.instr),
    .pc          (cmd_q.pc),
    .rs1_val     (cmd_q.rs1_val),
    .rs2_val     (cmd_q.rs2_val),
    .alu_op      (alu_op),
    .op1         (op1),
    .op2         (op2),
    .imm         (imm),
    .is_word_opt (is_word_opt),
    .is_jalr     (is_jalr),
    .legal       (legal),
    .bj_sel      (bj_sel)
  );

  ex_stage_alu i_ex_stage_alu (
    .op1         (op1),
    .op2         (op2),
    .alu_info    (alu_op),
    .is_word_opt (is_word_opt),
    .alu_output  (alu_output),
    .bj_data     (bj_data)
  );

  ex_branch_resolve i_ex_branch_resolve (
    .bj_data  (bj_data),
    .bj_sel   (bj_sel),
    .pc       (cmd_q.pc),
    .rs1_val  (cmd_q.rs1_val),
    .imm      (imm),
    .is_jalr  (is_jalr),
    .redirect (redirect),
    .next_pc  (next_pc)
  );

  always_comb begin
    res_d.rd_val   = alu_output;
    res_d.next_pc  = next_pc;
    res_d.rd_addr  = cmd_q.instr.r.rd;
    // x0 is never written
    res_d.wr_en    = legal && (cmd_q.instr.r.rd != 5'd0);
    res_d.redirect = redirect;
  end

endmodule

// ==== verification/ex_ref_model.svh ====
// reference model that derives the expected execute result of a command from the RV64I rules
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

function automatic ex_res_t ref_ex(input ex_cmd_t c);
  ex_res_t     r;
  logic [31:0] w;
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic        alt;
  logic        legal;
  logic        taken;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] v;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_b;
  logic [63:0] imm_j;
  logic [63:0] tgt;
  logic [31:0] lo;
  w     = c.instr;
  opc   = w[6:0];
  f3    = w[14:12];
  alt   = w[30];
  imm_i = {{52{w[31]}}, w[31:20]};
  imm_u = {{32{w[31]}}, w[31:12], 12'b0};
  imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  a     = c.rs1_val;
  b     = (opc == `OPC_OP_IMM || opc == `OPC_OP_IMM_32) ? imm_i : c.rs2_val;
  v     = '0;
  legal = 1'b0;
  taken = 1'b0;
  tgt   = c.pc + imm_b;
  case (opc)
    `OPC_OP, `OPC_OP_IMM: begin
      legal = 1'b1;
      case (f3)
        3'd0: v = (alt && opc == `OPC_OP) ? a - b : a + b;
        3'd1: v = a << b[5:0];
        3'd2: v = {63'b0, $signed(a) < $signed(b)};
        3'd3: v = {63'b0, a < b};
        3'd4: v = a ^ b;
        3'd5: begin
          if (alt) begin
            v = $signed(a) >>> b[5:0];
          end else begin
            v = a >> b[5:0];
          end
        end
        3'd6: v = a | b;
        default: v = (alt && opc == `OPC_OP) ? a & ~b : a & b;
      endcase
    end
    `OPC_OP_32, `OPC_OP_IMM_32: begin
      legal = 1'b1;
      case (f3)
        3'd0: lo = (alt && opc == `OPC_OP_32) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'd1: lo = a[31:0] << b[4:0];
        3'd5: begin
          if (alt) begin
            lo = $signed(a[31:0]) >>> b[4:0];
          end else begin
            lo = a[31:0] >> b[4:0];
          end
        end
        default: lo = '0;
      endcase
      v = {{32{lo[31]}}, lo};
    end
    `OPC_LUI: begin
      legal = 1'b1;
      v     = imm_u;
    end
    `OPC_AUIPC: begin
      legal = 1'b1;
      v     = c.pc + imm_u;
    end
    `OPC_JAL, `OPC_JALR: begin
      legal = 1'b1;
      taken = 1'b1;
      v     = c.pc + 64'd4;
      if (opc == `OPC_JAL) begin
        tgt = c.pc + imm_j;
      end else begin
        tgt    = a + imm_i;
        tgt[0] = 1'b0;
      end
    end
    `OPC_BRANCH: begin
      case (f3)
        3'd0: taken = a == b;
        3'd1: taken = a != b;
        3'd4: taken = $signed(a) < $signed(b);
        3'd5: taken = $signed(a) >= $signed(b);
        3'd6: taken = a < b;
        3'd7: taken = a >= b;
        default: taken = 1'b0;
      endcase
    end
    default: legal = 1'b0;
  endcase
  r.rd_val   = v;
  r.rd_addr  = w[11:7];
  r.wr_en    = legal && (w[11:7] != 5'd0);
  r.redirect = taken;
  r.next_pc  = taken ? tgt : c.pc + 64'd4;
  return r;
endfunction

`endif

// ==== verification/ex_stage_tb.sv ====
// testbench for the execute stage with LFSR commands checked against a reference model
`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_stage_tb import ex_pkg::*; ();

  localparam int CLK_NS    = 20;
  localparam int RST_CYC   = 10;
  localparam int N_ALU     = 60;
  localparam int N_SHIFT   = 128;
  localparam int N_WORD    = 64;
  localparam int N_BRANCH  = 48;
  localparam int N_ILLEGAL = 16;
  localparam int N_TOTAL   = N_ALU + N_SHIFT + N_WORD + N_BRANCH + N_ILLEGAL;

  logic        clk;
  logic        arst_n;
  logic        req;
  ex_cmd_t     cmd;
  logic        ack;
  ex_res_t     res;
  logic [31:0] lfsr = 32'd57;
  ex_cmd_t     sent_q[$];
  int          checks = 0;
  int          errors = 0;
  int          lens[5] = '{N_ALU, N_SHIFT, N_WORD, N_BRANCH, N_ILLEGAL};
  string       names[5] = '{"alu", "shift", "word", "branch", "illegal"};

  `include "ex_ref_model.svh"

  ex_stage i_ex_stage (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .cmd    (cmd),
    .ack    (ack),
    .res    (res)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // right-shift Galois LFSR with one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic rv_instr_u rand_instr(input logic [6:0] opc, input logic [2:0] f3);
    rv_instr_u   w;
    logic [63:0] t;
    t          = rand_bits(32);
    w          = rv_instr_u'(t[31:0]);
    w.r.opcode = opc;
    w.r.funct3 = f3;
    return w;
  endfunction

  task automatic make_stim(input int t, input int i, output rv_instr_u ins,
                           output logic [63:0] a, output logic [63:0] b);
    logic [63:0] r;
    logic [2:0]  f3;
    logic        lt;
    int          rel;
    a = rand_bits(64);
    b = rand_bits(64);
    r = rand_bits(10);
    case (t)
      0: begin
        f3 = r[2:0];
        if (r[3] && f3 != 3'd1 && f3 != 3'd5) begin
          ins = rand_instr(`OPC_OP_IMM, f3);
        end else begin
          ins          = rand_instr(`OPC_OP, f3);
          ins.r.funct7 = {1'b0, r[4] && (f3 == 3'd0 || f3 == 3'd7), 5'b0};
        end
        if (r[6:5] == 2'b11) begin
          ins.r.opcode = r[7] ? `OPC_LUI : `OPC_AUIPC;
        end
        if (i % 8 == 0) begin
          ins.r.rd = 5'd0;
        end
        // equal or nearly equal operands for the compares
        if (r[8]) begin
          b = a ^ {63'b0, r[9]};
        end
      end
      1: begin
        f3 = r[0] ? 3'd1 : 3'd5;
        if (r[1]) begin
          ins           = rand_instr(`OPC_OP_IMM, f3);
          ins.i.imm12   = {1'b0, f3 == 3'd5 && r[2], 4'b0, 6'(i)};
        end else begin
          ins          = rand_instr(`OPC_OP, f3);
          ins.r.funct7 = {1'b0, f3 == 3'd5 && r[2], 5'b0};
          b[5:0]       = 6'(i);
        end
      end
      2: begin
        f3 = (r[1:0] == 2'b00) ? 3'd0 : (r[1:0] == 2'b01) ? 3'd1 : 3'd5;
        if (r[2]) begin
          ins = rand_instr(`OPC_OP_IMM_32, f3);
          if (f3 != 3'd0) begin
            ins.i.imm12 = {1'b0, f3 == 3'd5 && r[3], 5'b0, 5'(i)};
          end
        end else begin
          ins          = rand_instr(`OPC_OP_32, f3);
          ins.r.funct7 = {1'b0, f3 != 3'd1 && r[3], 5'b0};
          b[4:0]       = 5'(i);
        end
      end
      3: begin
        if (i < 36) begin
          f3  = (i % 6 < 2) ? 3'(i % 6) : 3'(i % 6 + 2);
          ins = rand_instr(`OPC_BRANCH, f3);
          rel = (i / 6) % 3;
          if (rel == 0) begin
            b = a;
          end else begin
            if (a == b) begin
              b = ~a;
            end
            // order the pair for the signedness that this branch compares with
            lt = f3[1] ? (a < b) : ($signed(a) < $signed(b));
            if (lt != (rel == 1)) begin
              {a, b} = {b, a};
            end
          end
        end else if (i % 2 == 1) begin
          ins = rand_instr(`OPC_JALR, 3'd0);
        end else begin
          ins = rand_instr(`OPC_JAL, r[2:0]);
        end
      end
      default: begin
        ins = rand_instr(r[6:0], r[9:7]);
        while (ins.r.opcode inside {`OPC_OP, `OPC_OP_IMM, `OPC_OP_32, `OPC_OP_IMM_32,
                                    `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
                                    `OPC_BRANCH}) begin
          r            = rand_bits(7);
          ins.r.opcode = r[6:0];
        end
      end
    endcase
  endtask

  // one four-phase handshake, entered and left 2 ns after a rising edge with ack low
  task automatic send(input rv_instr_u ins, input logic [63:0] a, input logic [63:0] b);
    ex_cmd_t     c;
    logic [63:0] t;
    int          waited;
    t         = rand_bits(64);
    c.instr   = ins;
    c.pc      = {t[63:2], 2'b00};
    c.rs1_val = a;
    c.rs2_val = b;
    sent_q.push_back(c);
    cmd    = c;
    req    = 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      #2;
      waited++;
    end while (!ack);
    checks++;
    assert (waited == 2) else begin
      $display("** Error: %0t ns: ack came %0d cycles after acceptance instead of 1",
               $time, waited - 1);
      errors++;
    end
    req = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (ack);
  endtask

  initial begin
    ex_cmd_t c;
    ex_res_t want;
    logic    ok;
    forever begin
      @(posedge ack);
      #1;
      if (sent_q.size() == 0) begin
        $display("ack rose at %0t ns with no command outstanding", $time);
        errors++;
      end else begin
        c    = sent_q.pop_front();
        want = ref_ex(c);
        // rd_val only matters when the result is written
        ok   = res.next_pc == want.next_pc && res.redirect == want.redirect &&
               res.wr_en == want.wr_en && res.rd_addr == want.rd_addr &&
               (!want.wr_en || res.rd_val == want.rd_val);
        checks++;
        assert (ok) else begin
          $display("** Error: %0t ns: instr %h pc %h rs1 %h rs2 %h got %h expected %h",
                   $time, c.instr, c.pc, c.rs1_val, c.rs2_val, res, want);
          errors++;
        end
      end
    end
  end

  initial begin
    #((N_TOTAL * 10 + RST_CYC) * CLK_NS);
    $display("timeout at %0t ns because ack never arrived for a pending request", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rv_instr_u   ins;
    logic [63:0] a;
    logic [63:0] b;
    int          base;
    arst_n = 1'b0;
    req    = 1'b0;
    cmd    = '0;
    repeat (RST_CYC) @(posedge clk);
    #2;
    arst_n = 1'b1;
    base   = errors;
    repeat (3) begin
      @(posedge clk);
      #2;
      checks++;
      assert (!ack && res == '0) else begin
        $display("** Error: %0t ns: ack %b res %h before any request", $time, ack, res);
        errors++;
      end
    end
    $display("test reset: 0 commands, %0d errors", errors - base);
    for (int t = 0; t < 5; t++) begin
      base = errors;
      for (int i = 0; i < lens[t]; i++) begin
        make_stim(t, i, ins, a, b);
        send(ins, a, b);
      end
      $display("test %s: %0d commands, %0d errors", names[t], lens[t], errors - base);
    end
    $display("6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verilog
+incdir+verification
verilog/ex_pkg.sv
verilog/ex_decoder.sv
verilog/ex_stage_alu.sv
verilog/ex_branch_resolve.sv
verilog/ex_stage.sv
verification/ex_stage_tb.sv

// ==== Makefile ====
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --timescale 1ns/10ps -f compile.f \
		--top-module ex_stage_tb -Mdir obj_dir
	./obj_dir/Vex_stage_tb > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@if grep -q "TEST RESULT: FAIL" $(SIM_LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
